// ==== source/gfx_pkg.sv ====
package gfx_pkg;

  // Coordinate width covers the active area and the 24-count line counter.
  localparam int COORD_W = 5;

  // Width of one color channel.
  localparam int COLOR_W = 4;

  // 12-bit color, red in the top bits and blue in the bottom bits.
  typedef struct packed {
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } rgb_t;

  // Filled rectangles write every position of the box, outlines only the border.
  typedef enum logic {
    SHAPE_FILL    = 1'b0,
    SHAPE_OUTLINE = 1'b1
  } shape_e;

endpackage

// ==== source/gfx_px_if.sv ====
`timescale 1ns/1ps

// Pixel writes travel from the drawer to the arbiter.
// Credits travel back, one pulse per pixel retired into memory.
interface gfx_px_if import gfx_pkg::*; ();

  logic               px_valid;
  logic [COORD_W-1:0] px_x;
  logic [COORD_W-1:0] px_y;
  rgb_t               px_color;
  logic               credit;

  modport source (
    output px_valid,
    output px_x,
    output px_y,
    output px_color,
    input  credit
  );

  modport sink (
    input  px_valid,
    input  px_x,
    input  px_y,
    input  px_color,
    output credit
  );

endinterface

// ==== source/gfx_rect_draw.sv ====
`timescale 1ns/1ps

module gfx_rect_draw import gfx_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  input  shape_e             cmd_kind,
  input  logic [COORD_W-1:0] cmd_x0,
  input  logic [COORD_W-1:0] cmd_y0,
  input  logic [COORD_W-1:0] cmd_x1,
  input  logic [COORD_W-1:0] cmd_y1,
  input  rgb_t               cmd_color,
  output logic               cmd_ready,
  gfx_px_if.source           px
);

  localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

  logic                busy;
  logic [CREDIT_W-1:0] credits;

  shape_e             kind;
  logic [COORD_W-1:0] x0;
  logic [COORD_W-1:0] y0;
  logic [COORD_W-1:0] x1;
  logic [COORD_W-1:0] y1;
  rgb_t               color;
  logic [COORD_W-1:0] cur_x;
  logic [COORD_W-1:0] cur_y;

  logic last_col;
  logic last_row;
  logic on_border;
  logic emit;
  logic step;
  logic accept;

  assign accept    = cmd_valid && cmd_ready;
  assign cmd_ready = !busy;

  assign last_col  = (cur_x == x1);
  assign last_row  = (cur_y == y1);
  assign on_border = (cur_x == x0) || last_col || (cur_y == y0) || last_row;
  assign emit      = (kind == SHAPE_FILL) || on_border;

  // Interior positions of an outline are passed over without needing a credit.
  assign step = busy && (!emit || (credits != '0));

  assign px.px_valid = busy && emit && (credits != '0);
  assign px.px_x     = cur_x;
  assign px.px_y     = cur_y;
  assign px.px_color = color;

  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      busy    <= 1'b0;
      credits <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      // A returned credit and a spent one may land on the same edge.
      credits <= credits + CREDIT_W'(px.credit) - CREDIT_W'(px.px_valid);
      if (accept) begin
        busy <= 1'b1;
      end else if (step && last_col && last_row) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (accept) begin
      kind  <= cmd_kind;
      x0    <= cmd_x0;
      y0    <= cmd_y0;
      x1    <= cmd_x1;
      y1    <= cmd_y1;
      color <= cmd_color;
      cur_x <= cmd_x0;
      cur_y <= cmd_y0;
    end else if (step) begin
      if (last_col) begin
        cur_x <= x0;
        if (!last_row) begin
          cur_y <= cur_y + 1'b1;
        end
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

endmodule

// ==== source/gfx_fb_arbiter.sv ====
`timescale 1ns/1ps

module gfx_fb_arbiter import gfx_pkg::*; #(
  parameter int H_ACTIVE   = 16,
  parameter int V_ACTIVE   = 12,
  parameter int FIFO_DEPTH = 4
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               fetch,
  input  logic [COORD_W-1:0] fetch_x,
  input  logic [COORD_W-1:0] fetch_y,
  output rgb_t               fetch_color,
  gfx_px_if.sink             px
);

  localparam int MEM_DEPTH = H_ACTIVE * V_ACTIVE;
  localparam int ADDR_W    = $clog2(MEM_DEPTH);
  localparam int PTR_W     = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W     = $clog2(FIFO_DEPTH + 1);

  rgb_t mem [MEM_DEPTH];

  logic [COORD_W-1:0] q_x     [FIFO_DEPTH];
  logic [COORD_W-1:0] q_y     [FIFO_DEPTH];
  rgb_t               q_color [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic              push;
  logic              pop;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;

  // Scan-out owns the memory during active video, so writes only drain in blanking.
  assign push = px.px_valid;
  assign pop  = !fetch && (count != '0);

  assign px.credit = pop;

  assign rd_addr = ADDR_W'(fetch_y) * ADDR_W'(H_ACTIVE) + ADDR_W'(fetch_x);
  assign wr_addr = ADDR_W'(q_y[rd_ptr]) * ADDR_W'(H_ACTIVE) + ADDR_W'(q_x[rd_ptr]);

  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (push) begin
      q_x[wr_ptr]     <= px.px_x;
      q_y[wr_ptr]     <= px.px_y;
      q_color[wr_ptr] <= px.px_color;
    end
  end

  // One port: a read when scan-out fetches, otherwise a write of the queue head.
  always_ff @(posedge pixel_clk) begin
    if (fetch) begin
      fetch_color <= mem[rd_addr];
    end else if (pop) begin
      mem[wr_addr] <= q_color[rd_ptr];
    end
  end

endmodule

// ==== source/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing import gfx_pkg::*; #(
  parameter int H_ACTIVE = 16,
  parameter int H_FP     = 2,
  parameter int H_SYNC   = 3,
  parameter int H_BP     = 3,
  parameter int V_ACTIVE = 12,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 1
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  rgb_t               fetch_color,
  output logic               fetch,
  output logic [COORD_W-1:0] fetch_x,
  output logic [COORD_W-1:0] fetch_y,
  output logic               hsync,
  output logic               vsync,
  output logic               de,
  output rgb_t               rgb
);

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  localparam logic [COORD_W-1:0] H_LAST      = COORD_W'(H_TOTAL - 1);
  localparam logic [COORD_W-1:0] V_LAST      = COORD_W'(V_TOTAL - 1);
  localparam logic [COORD_W-1:0] H_ACT_END   = COORD_W'(H_ACTIVE);
  localparam logic [COORD_W-1:0] V_ACT_END   = COORD_W'(V_ACTIVE);
  localparam logic [COORD_W-1:0] H_SYNC_BEG  = COORD_W'(H_ACTIVE + H_FP);
  localparam logic [COORD_W-1:0] H_SYNC_END  = COORD_W'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [COORD_W-1:0] V_SYNC_BEG  = COORD_W'(V_ACTIVE + V_FP);
  localparam logic [COORD_W-1:0] V_SYNC_END  = COORD_W'(V_ACTIVE + V_FP + V_SYNC);

  logic [COORD_W-1:0] h_cnt;
  logic [COORD_W-1:0] v_cnt;

  logic active;
  logic hsync_raw;
  logic vsync_raw;
  logic hsync_d1;
  logic vsync_d1;
  logic de_d1;

  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign active    = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
  // Sync pulses are active low.
  assign hsync_raw = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
  assign vsync_raw = !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));

  assign fetch   = active;
  assign fetch_x = h_cnt;
  assign fetch_y = v_cnt;

  // The first stage waits out the memory read, the second stage lines up with the color.
  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      hsync_d1 <= 1'b1;
      vsync_d1 <= 1'b1;
      de_d1    <= 1'b0;
      hsync    <= 1'b1;
      vsync    <= 1'b1;
      de       <= 1'b0;
      rgb      <= '0;
    end else begin
      hsync_d1 <= hsync_raw;
      vsync_d1 <= vsync_raw;
      de_d1    <= active;
      hsync    <= hsync_d1;
      vsync    <= vsync_d1;
      de       <= de_d1;
      rgb      <= de_d1 ? fetch_color : '0;
    end
  end

endmodule

// ==== source/gfx_demo_top.sv ====
`timescale 1ns/1ps

module gfx_demo_top import gfx_pkg::*; #(
  parameter int H_ACTIVE   = 16,
  parameter int H_FP       = 2,
  parameter int H_SYNC     = 3,
  parameter int H_BP       = 3,
  parameter int V_ACTIVE   = 12,
  parameter int V_FP       = 1,
  parameter int V_SYNC     = 2,
  parameter int V_BP       = 1,
  parameter int FIFO_DEPTH = 4
) (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  input  shape_e             cmd_kind,
  input  logic [COORD_W-1:0] cmd_x0,
  input  logic [COORD_W-1:0] cmd_y0,
  input  logic [COORD_W-1:0] cmd_x1,
  input  logic [COORD_W-1:0] cmd_y1,
  input  rgb_t               cmd_color,
  output logic               cmd_ready,
  output logic               hsync,
  output logic               vsync,
  output logic               de,
  output logic [COLOR_W-1:0] red,
  output logic [COLOR_W-1:0] grn,
  output logic [COLOR_W-1:0] blu
);

  logic               fetch;
  logic [COORD_W-1:0] fetch_x;
  logic [COORD_W-1:0] fetch_y;
  rgb_t               fetch_color;
  rgb_t               rgb;

  gfx_px_if px_bus ();

  gfx_rect_draw #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) gfx_rect_draw_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_kind  (cmd_kind),
    .cmd_x0    (cmd_x0),
    .cmd_y0    (cmd_y0),
    .cmd_x1    (cmd_x1),
    .cmd_y1    (cmd_y1),
    .cmd_color (cmd_color),
    .cmd_ready (cmd_ready),
    .px        (px_bus.source)
  );

  gfx_fb_arbiter #(
    .H_ACTIVE   (H_ACTIVE),
    .V_ACTIVE   (V_ACTIVE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) gfx_fb_arbiter_inst (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .fetch       (fetch),
    .fetch_x     (fetch_x),
    .fetch_y     (fetch_y),
    .fetch_color (fetch_color),
    .px          (px_bus.sink)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) vga_timing_inst (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .fetch_color (fetch_color),
    .fetch       (fetch),
    .fetch_x     (fetch_x),
    .fetch_y     (fetch_y),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .rgb         (rgb)
  );

  assign red = rgb.red;
  assign grn = rgb.green;
  assign blu = rgb.blue;

endmodule

// ==== verif/gfx_demo_assert.sv ====
`timescale 1ns/1ps

module gfx_demo_assert import gfx_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input logic                                 pixel_clk,
  input logic                                 rst_n,
  input logic [$clog2(FIFO_DEPTH + 1)-1:0]    credits,
  input logic                                 px_valid,
  input logic                                 credit,
  input logic                                 fetch,
  input logic                                 de,
  input rgb_t                                 rgb
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Pixels sent across the interface that memory has not yet retired.
  logic [CNT_W-1:0] in_flight;

  always_ff @(posedge pixel_clk) begin
    if (rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + CNT_W'(px_valid) - CNT_W'(credit);
    end
  end

  credits_in_range_a : assert property (
    @(posedge pixel_clk) disable iff (rst_n) credits <= FIFO_DEPTH
  ) else $error("Credit count exceeds the queue depth.");

  valid_needs_credit_a : assert property (
    @(posedge pixel_clk) disable iff (rst_n) px_valid |-> (in_flight < FIFO_DEPTH)
  ) else $error("Pixel write issued with no credit left.");

  // Output trails the read slot by two cycles, so a blanking position shows up black.
  blank_is_black_a : assert property (
    @(posedge pixel_clk) disable iff (rst_n) !$past(fetch, 2) |-> (!de && (rgb == '0))
  ) else $error("Color output is not blank outside the fetched positions.");

endmodule

// The drawer instance checks the credit protocol and the video instance checks blanking.
bind gfx_rect_draw gfx_demo_assert #(
  .FIFO_DEPTH (FIFO_DEPTH)
) draw_assert_inst (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .credits   (credits),
  .px_valid  (px.px_valid),
  .credit    (px.credit),
  .fetch     (1'b1),
  .de        (1'b0),
  .rgb       ('0)
);

bind vga_timing gfx_demo_assert video_assert_inst (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .credits   ('0),
  .px_valid  (1'b0),
  .credit    (1'b0),
  .fetch     (fetch),
  .de        (de),
  .rgb       (rgb)
);

// ==== verif/gfx_demo_tb.sv ====
`timescale 1ns/1ps

module gfx_demo_tb import gfx_pkg::*; ();

  localparam int H_ACTIVE     = 16;
  localparam int H_SYNC       = 3;
  localparam int H_TOTAL      = 24;
  localparam int V_ACTIVE     = 12;
  localparam int FRAME_CYCLES = H_TOTAL * 16;
  localparam int NUM_PIXELS   = H_ACTIVE * V_ACTIVE;
  localparam realtime CLK_PERIOD = 40.0;
  // Six tests of about four frames each, plus twelve frames of margin.
  localparam realtime RUN_LIMIT = (6 * 4 + 12) * FRAME_CYCLES * CLK_PERIOD;

  logic               pixel_clk;
  logic               rst_n;
  logic               cmd_valid;
  shape_e             cmd_kind;
  logic [COORD_W-1:0] cmd_x0;
  logic [COORD_W-1:0] cmd_y0;
  logic [COORD_W-1:0] cmd_x1;
  logic [COORD_W-1:0] cmd_y1;
  rgb_t               cmd_color;
  logic               cmd_ready;
  logic               hsync;
  logic               vsync;
  logic               de;
  logic [COLOR_W-1:0] red;
  logic [COLOR_W-1:0] grn;
  logic [COLOR_W-1:0] blu;

  logic [11:0] model [NUM_PIXELS];
  logic [7:0]  lfsr_state;

  gfx_demo_top gfx_demo_top_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_kind  (cmd_kind),
    .cmd_x0    (cmd_x0),
    .cmd_y0    (cmd_y0),
    .cmd_x1    (cmd_x1),
    .cmd_y1    (cmd_y1),
    .cmd_color (cmd_color),
    .cmd_ready (cmd_ready),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .red       (red),
    .grn       (grn),
    .blu       (blu)
  );

  always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR with taps 8, 6, 5, 4, one step per bit.
  function automatic int rand_bits(input int n);
    int   value;
    logic fb;
    value = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
      lfsr_state = {lfsr_state[6:0], fb};
      value = (value << 1) | int'(fb);
    end
    return value;
  endfunction

  task automatic wait_vsync_fall();
    logic prev;
    prev = vsync;
    forever begin
      @(negedge pixel_clk);
      if (prev && !vsync) break;
      prev = vsync;
    end
  endtask

  task automatic update_model(input shape_e kind, input int x0, input int y0,
                              input int x1, input int y1, input logic [11:0] color);
    for (int y = y0; y <= y1; y++) begin
      for (int x = x0; x <= x1; x++) begin
        if (kind == SHAPE_FILL || x == x0 || x == x1 || y == y0 || y == y1) begin
          model[y * H_ACTIVE + x] = color;
        end
      end
    end
  endtask

  // Issues one command, waits for the drawer to go idle again and updates the model.
  task automatic draw_rect(input shape_e kind, input int x0, input int y0,
                           input int x1, input int y1, input logic [11:0] color);
    while (!cmd_ready) @(negedge pixel_clk);
    @(posedge pixel_clk);
    cmd_valid <= 1'b1;
    cmd_kind  <= kind;
    cmd_x0    <= COORD_W'(x0);
    cmd_y0    <= COORD_W'(y0);
    cmd_x1    <= COORD_W'(x1);
    cmd_y1    <= COORD_W'(y1);
    cmd_color <= color;
    @(posedge pixel_clk);
    cmd_valid <= 1'b0;
    do @(negedge pixel_clk); while (!cmd_ready);
    update_model(kind, x0, y0, x1, y1, color);
  endtask

  task automatic capture_frame();
    int idx;
    wait_vsync_fall();
    wait_vsync_fall();
    idx = 0;
    while (idx < NUM_PIXELS) begin
      @(negedge pixel_clk);
      if (de) begin
        check_value($sformatf("rgb at (%0d,%0d)", idx % H_ACTIVE, idx / H_ACTIVE),
                    {red, grn, blu}, model[idx]);
        idx++;
      end
    end
  endtask

  task automatic test_reset_state();
    @(negedge pixel_clk);
    check_value("hsync", hsync, 1);
    check_value("vsync", vsync, 1);
    check_value("de", de, 0);
    check_value("rgb", {red, grn, blu}, 0);
    check_value("cmd_ready", cmd_ready, 1);
  endtask

  task automatic test_sync_structure();
    int   cycles;
    int   de_run;
    int   de_lines;
    int   hs_run;
    int   last_fall;
    logic prev_hs;
    logic prev_de;
    logic prev_vs;
    logic done;
    wait_vsync_fall();
    cycles    = 0;
    de_run    = 0;
    de_lines  = 0;
    hs_run    = 0;
    last_fall = -1;
    prev_hs   = hsync;
    prev_de   = de;
    prev_vs   = vsync;
    do begin
      @(negedge pixel_clk);
      cycles++;
      if (de) de_run++;
      if (prev_de && !de) begin
        check_value("de run length", de_run, H_ACTIVE);
        de_run = 0;
        de_lines++;
      end
      if (!hsync) hs_run++;
      if (prev_hs && !hsync) begin
        if (last_fall >= 0) check_value("hsync period", cycles - last_fall, H_TOTAL);
        last_fall = cycles;
      end
      if (!prev_hs && hsync) begin
        check_value("hsync width", hs_run, H_SYNC);
        hs_run = 0;
      end
      done    = prev_vs && !vsync;
      prev_hs = hsync;
      prev_de = de;
      prev_vs = vsync;
    end while (!done);
    check_value("vsync period", cycles, FRAME_CYCLES);
    check_value("de lines per frame", de_lines, V_ACTIVE);
  endtask

  task automatic test_full_fill();
    draw_rect(SHAPE_FILL, 0, 0, H_ACTIVE - 1, V_ACTIVE - 1, 12'(rand_bits(12)));
    capture_frame();
  endtask

  task automatic test_random_fills();
    int a;
    int b;
    int c;
    int d;
    for (int n = 0; n < 3; n++) begin
      a = rand_bits(4);
      b = rand_bits(4);
      c = rand_bits(4) % V_ACTIVE;
      d = rand_bits(4) % V_ACTIVE;
      draw_rect(SHAPE_FILL, (a < b) ? a : b, (c < d) ? c : d, (a < b) ? b : a,
                (c < d) ? d : c, 12'(rand_bits(12)));
      capture_frame();
    end
  endtask

  task automatic test_outline();
    logic [11:0] bg;
    bg = 12'(rand_bits(12));
    draw_rect(SHAPE_FILL, 0, 0, H_ACTIVE - 1, V_ACTIVE - 1, bg);
    draw_rect(SHAPE_OUTLINE, 3, 2, 12, 9, bg ^ 12'hfff);
    capture_frame();
  endtask

  task automatic test_overlap();
    logic [11:0] first;
    first = 12'(rand_bits(12));
    draw_rect(SHAPE_FILL, 1, 1, 9, 7, first);
    draw_rect(SHAPE_FILL, 5, 4, 14, 10, first ^ 12'h5a5);
    capture_frame();
  endtask

  initial begin
    #(RUN_LIMIT);
    $display("Watchdog: the simulation ran past its time limit before the tests finished.");
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin
    pixel_clk  = 1'b0;
    rst_n      = 1'b1;
    cmd_valid  = 1'b0;
    cmd_kind   = SHAPE_FILL;
    cmd_x0     = '0;
    cmd_y0     = '0;
    cmd_x1     = '0;
    cmd_y1     = '0;
    cmd_color  = '0;
    lfsr_state = 8'd85;
    repeat (3) @(posedge pixel_clk);
    rst_n <= 1'b0;
    test_reset_state();
    test_sync_structure();
    test_full_fill();
    test_random_fills();
    test_outline();
    test_overlap();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
source/gfx_pkg.sv
source/gfx_px_if.sv
source/gfx_rect_draw.sv
source/gfx_fb_arbiter.sv
source/vga_timing.sv
source/gfx_demo_top.sv
verif/gfx_demo_assert.sv
verif/gfx_demo_tb.sv

// ==== Bender.yml ====
package:
  name: gfx_demo

sources:
  - files:
      - source/gfx_pkg.sv
      - source/gfx_px_if.sv
      - source/gfx_rect_draw.sv
      - source/gfx_fb_arbiter.sv
      - source/vga_timing.sv
      - source/gfx_demo_top.sv
  - target: test
    files:
      - verif/gfx_demo_assert.sv
      - verif/gfx_demo_tb.sv
